//--- build.f
+incdir+include
rtl/kbd_pkg.sv
rtl/ps2_frame_rx.sv
rtl/key_event_ctrl.sv
rtl/scan_fifo.sv
rtl/seg_display.sv
rtl/kbd_top.sv
testbench/tb_kbd_top.sv

//--- include/kbd_settings.svh
`ifndef KBD_SETTINGS_SVH
`define KBD_SETTINGS_SVH

// ------------------------------------------------------------
// Queue and receiver sizing
// ------------------------------------------------------------
`define KBD_FIFO_DEPTH 8
`define KBD_SYNC_STAGES 3

// ------------------------------------------------------------
// Scan code set 2 prefixes
// ------------------------------------------------------------
`define KBD_BREAK_CODE 8'hF0
`define KBD_EXT_CODE 8'hE0

`endif

//--- rtl/kbd_pkg.sv
`default_nettype none

package kbd_pkg;

    // ------------------------------------------------------------
    // Receiver output
    // ------------------------------------------------------------
    typedef struct packed {
        logic [7:0] data;   // Data byte, LSB first on the wire.
        logic       err;    // Start, parity or stop bit was wrong.
    } ps2_frame_t;

    // ------------------------------------------------------------
    // Queued key
    // ------------------------------------------------------------
    typedef struct packed {
        logic       ext;    // Code came after an E0 prefix.
        logic [7:0] code;   // Make code.
    } key_entry_t;

    // Active low, segment a in the MSB down to g in the LSB.
    typedef logic [6:0] seg_t;

endpackage

`default_nettype wire

//--- rtl/kbd_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "kbd_settings.svh"

module kbd_top
    import kbd_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             ps2_clk,
    input  logic             ps2_data,
    input  logic             next_key,
    output key_entry_t       head,
    output logic             key_ready,
    output logic             overflow,
    output logic             frame_error,
    output seg_t       [5:0] seg
);

    ps2_frame_t frame;
    logic       frame_valid;
    key_entry_t push_entry;
    logic       push;
    logic [7:0] press_count;
    logic [$clog2(`KBD_FIFO_DEPTH+1)-1:0] level;

    // ------------------------------------------------------------
    // Receive path
    // ------------------------------------------------------------
    ps2_frame_rx rx0 (
        .clk         (clk),
        .rst         (rst),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .frame       (frame),
        .frame_valid (frame_valid)
    );

    key_event_ctrl ctrl0 (
        .clk         (clk),
        .rst         (rst),
        .frame       (frame),
        .frame_valid (frame_valid),
        .push_entry  (push_entry),
        .push        (push),
        .press_count (press_count),
        .frame_error (frame_error)
    );

    // ------------------------------------------------------------
    // Queue and display
    // ------------------------------------------------------------
    scan_fifo #(
        .item_t (key_entry_t),
        .DEPTH  (`KBD_FIFO_DEPTH)
    ) fifo0 (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (push_entry),
        .pop       (next_key),
        .head      (head),
        .not_empty (key_ready),
        .level     (level),
        .overflow  (overflow)
    );

    seg_display disp0 (
        .head        (head),
        .not_empty   (key_ready),
        .press_count (press_count),
        .level       (level),
        .seg         (seg)
    );

endmodule

`default_nettype wire

//--- rtl/key_event_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

`include "kbd_settings.svh"

module key_event_ctrl
    import kbd_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  ps2_frame_t frame,
    input  logic       frame_valid,
    output key_entry_t push_entry,
    output logic       push,
    output logic [7:0] press_count,
    output logic       frame_error
);

    logic       brk_pend;
    logic       ext_pend;
    logic       held_valid;
    key_entry_t held;
    key_entry_t rx_entry;
    logic       held_match;
    logic       is_prefix;

    // Code as it would be queued, with the pending extended flag.
    assign rx_entry.ext  = ext_pend;
    assign rx_entry.code = frame.data;

    assign held_match = held_valid && (held == rx_entry);

    assign is_prefix = (frame.data == `KBD_EXT_CODE) || (frame.data == `KBD_BREAK_CODE);

    // ------------------------------------------------------------
    // Prefix decode, push and press counting
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            brk_pend    <= 1'b0;
            ext_pend    <= 1'b0;
            held_valid  <= 1'b0;
            push        <= 1'b0;
            press_count <= '0;
            frame_error <= 1'b0;
        end else begin
            push <= 1'b0;
            if (frame_valid) begin
                if (frame.err) begin
                    frame_error <= 1'b1;           // Sticky.
                end else if (frame.data == `KBD_EXT_CODE) begin
                    ext_pend <= 1'b1;
                end else if (frame.data == `KBD_BREAK_CODE) begin
                    brk_pend <= 1'b1;
                end else if (brk_pend) begin
                    // Release of a key, never queued
                    brk_pend <= 1'b0;
                    ext_pend <= 1'b0;
                    if (held_match) begin
                        held_valid <= 1'b0;
                    end
                end else begin
                    push     <= 1'b1;
                    brk_pend <= 1'b0;
                    ext_pend <= 1'b0;
                    if (!held_match) begin
                        press_count <= press_count + 8'd1;   // Wraps at 256.
                        held_valid  <= 1'b1;
                    end
                end
            end
        end
    end

    // Payload registers, read only together with push or held_valid.
    always_ff @(posedge clk) begin
        if (frame_valid && !frame.err) begin
            push_entry <= rx_entry;
            if (!is_prefix && !brk_pend && !held_match) begin
                held <= rx_entry;                  // New make code only.
            end
        end
    end

    a_push_after_frame: assert property (
        @(posedge clk) disable iff (rst) push |-> $past(frame_valid)
    );

endmodule

`default_nettype wire

//--- rtl/ps2_frame_rx.sv
`default_nettype none
`timescale 1ns/1ps

`include "kbd_settings.svh"

module ps2_frame_rx
    import kbd_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output ps2_frame_t frame,
    output logic       frame_valid
);

    localparam int SYNC = `KBD_SYNC_STAGES;

    logic [SYNC-1:0] clk_sync;
    logic            clk_fall;
    logic [10:0]     shift;
    logic [10:0]     bits_next;
    logic [3:0]      bit_cnt;
    logic            frame_ok;

    // ------------------------------------------------------------
    // PS/2 clock synchronizer and falling edge detect
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            clk_sync <= '1;                        // Line idles high.
        end else begin
            clk_sync <= {clk_sync[SYNC-2:0], ps2_clk};
        end
    end

    assign clk_fall = clk_sync[SYNC-1] & ~clk_sync[SYNC-2];

    // Bits arrive LSB first, so shift in from the top.
    assign bits_next = {ps2_data, shift[10:1]};

    // start = 0, stop = 1, odd parity over data and parity bit
    assign frame_ok = ~bits_next[0] & bits_next[10] & (^bits_next[9:1]);

    // ------------------------------------------------------------
    // Bit counter and frame assembly
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt     <= '0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= 1'b0;
            if (clk_fall) begin
                if (bit_cnt == 4'd10) begin
                    bit_cnt     <= '0;                 // Stop bit, restart.
                    frame_valid <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clk_fall) begin
            shift <= bits_next;
            if (bit_cnt == 4'd10) begin
                frame.data <= bits_next[8:1];
                frame.err  <= ~frame_ok;
            end
        end
    end

    a_valid_single: assert property (
        @(posedge clk) disable iff (rst) frame_valid |=> !frame_valid
    );

endmodule

`default_nettype wire

//--- rtl/scan_fifo.sv
`default_nettype none
`timescale 1ns/1ps

`include "kbd_settings.svh"

module scan_fifo #(
    parameter type item_t = logic [7:0],
    parameter int  DEPTH  = `KBD_FIFO_DEPTH
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       push,
    input  item_t                      push_data,
    input  logic                       pop,
    output item_t                      head,
    output logic                       not_empty,
    output logic [$clog2(DEPTH+1)-1:0] level,
    output logic                       overflow
);

    localparam int AW = $clog2(DEPTH);

    item_t       mem [DEPTH];
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        empty;
    logic        full;
    logic        do_push;
    logic        do_pop;

    // ------------------------------------------------------------
    // Pointer status
    // ------------------------------------------------------------
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                   (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign do_pop  = pop & ~empty;             // Pop on empty is ignored.
    assign do_push = push & (~full | do_pop);

    assign not_empty = ~empty;
    assign level     = wr_ptr - rd_ptr;
    assign head      = mem[rd_ptr[AW-1:0]];

    // ------------------------------------------------------------
    // Pointers and overflow
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !do_push) begin
                overflow <= 1'b1;                  // Entry dropped.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= push_data;
        end
    end

    a_level_bound: assert property (
        @(posedge clk) disable iff (rst) level <= DEPTH
    );

endmodule

`default_nettype wire

//--- rtl/seg_display.sv
`default_nettype none
`timescale 1ns/1ps

module seg_display
    import kbd_pkg::*;
(
    input  key_entry_t       head,
    input  logic             not_empty,
    input  logic [7:0]       press_count,
    input  logic [3:0]       level,
    output seg_t       [5:0] seg
);

    localparam seg_t SEG_BLANK = 7'b1111111;

    logic [3:0] ones;
    logic [3:0] tens;
    logic [3:0] hundreds;

    // ------------------------------------------------------------
    // Hex glyphs, segments a..g, active low
    // ------------------------------------------------------------
    function automatic seg_t hex_glyph(input logic [3:0] d);
        case (d)
            4'h0:    return 7'b0000001;
            4'h1:    return 7'b1001111;
            4'h2:    return 7'b0010010;
            4'h3:    return 7'b0000110;
            4'h4:    return 7'b1001100;
            4'h5:    return 7'b0100100;
            4'h6:    return 7'b0100000;
            4'h7:    return 7'b0001111;
            4'h8:    return 7'b0000000;
            4'h9:    return 7'b0000100;
            4'hA:    return 7'b0001000;
            4'hB:    return 7'b1100000;    // Lower case b.
            4'hC:    return 7'b0110001;
            4'hD:    return 7'b1000010;    // Lower case d.
            4'hE:    return 7'b0110000;
            default: return 7'b0111000;    // F.
        endcase
    endfunction

    // Decimal split of the press count
    assign ones     = 4'(press_count % 8'd10);
    assign tens     = 4'((press_count / 8'd10) % 8'd10);
    assign hundreds = 4'(press_count / 8'd100);

    // ------------------------------------------------------------
    // Digit select
    // ------------------------------------------------------------
    always_comb begin
        if (not_empty) begin
            seg[0] = hex_glyph(head.code[3:0]);
            seg[1] = hex_glyph(head.code[7:4]);
        end else begin
            seg[0] = SEG_BLANK;
            seg[1] = SEG_BLANK;
        end

        seg[2] = hex_glyph(ones);                  // Units always lit.

        if (hundreds == 4'd0 && tens == 4'd0) begin
            seg[3] = SEG_BLANK;
        end else begin
            seg[3] = hex_glyph(tens);
        end

        if (hundreds == 4'd0) begin
            seg[4] = SEG_BLANK;
        end else begin
            seg[4] = hex_glyph(hundreds);
        end

        seg[5] = hex_glyph(level);
    end

endmodule

`default_nettype wire

//--- testbench/tb_kbd_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "kbd_settings.svh"

module tb_kbd_top
    import kbd_pkg::*;
;

    localparam int   FRAME_COUNT = 42;                        // Frames sent by all tests.
    localparam int   CYCLE_LIMIT = FRAME_COUNT * 11 * 20 * 3 / 2;
    localparam int   SETTLE      = 8;                         // Cycles after the stop bit.
    localparam seg_t BLANK       = 7'b1111111;

    logic             clk;
    logic             rst;
    logic             ps2_clk;
    logic             ps2_data;
    logic             next_key;
    key_entry_t       head;
    logic             key_ready;
    logic             overflow;
    logic             frame_error;
    seg_t       [5:0] seg;

    // Reference model state
    key_entry_t exp_q [$];
    logic [7:0] exp_count;
    logic       exp_overflow;
    logic       exp_frame_error;
    logic       brk_pend;
    logic       ext_pend;
    logic       held_valid;
    key_entry_t held;

    seg_t   glyph [16];
    int     n_checks;
    int     n_errors;
    int     cycle_cnt;
    integer seed;

    kbd_top dut0 (
        .clk         (clk),
        .rst         (rst),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .next_key    (next_key),
        .head        (head),
        .key_ready   (key_ready),
        .overflow    (overflow),
        .frame_error (frame_error),
        .seg         (seg)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
            $display("Checks: %0d, errors: %0d", n_checks, n_errors + 1);
            $display("Simulation failed");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_entry(input string name, input key_entry_t exp, input key_entry_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_seg(input string name, input seg_t exp, input seg_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input bit exp, input logic act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input logic [7:0] exp, input logic [7:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    task automatic load_glyphs;
        glyph[0]  = 7'b0000001;
        glyph[1]  = 7'b1001111;
        glyph[2]  = 7'b0010010;
        glyph[3]  = 7'b0000110;
        glyph[4]  = 7'b1001100;
        glyph[5]  = 7'b0100100;
        glyph[6]  = 7'b0100000;
        glyph[7]  = 7'b0001111;
        glyph[8]  = 7'b0000000;
        glyph[9]  = 7'b0000100;
        glyph[10] = 7'b0001000;
        glyph[11] = 7'b1100000;
        glyph[12] = 7'b0110001;
        glyph[13] = 7'b1000010;
        glyph[14] = 7'b0110000;
        glyph[15] = 7'b0111000;
    endtask

    task automatic model_frame(input logic [7:0] data, input bit bad);
        key_entry_t e;
        e.ext  = ext_pend;
        e.code = data;
        if (bad) begin
            exp_frame_error = 1'b1;
        end else if (data == `KBD_EXT_CODE) begin
            ext_pend = 1'b1;
        end else if (data == `KBD_BREAK_CODE) begin
            brk_pend = 1'b1;
        end else if (brk_pend) begin
            if (held_valid && held == e) begin
                held_valid = 1'b0;                            // Held key released.
            end
            brk_pend = 1'b0;
            ext_pend = 1'b0;
        end else begin
            if (exp_q.size() < `KBD_FIFO_DEPTH) begin
                exp_q.push_back(e);
            end else begin
                exp_overflow = 1'b1;
            end
            if (!(held_valid && held == e)) begin
                exp_count  = exp_count + 8'd1;
                held       = e;
                held_valid = 1'b1;
            end
            ext_pend = 1'b0;
        end
    endtask

    task automatic check_state;
        seg_t       exp_seg [6];
        int         lvl;
        logic [7:0] cnt;
        lvl = exp_q.size();
        cnt = exp_count;
        check_flag("key_ready", lvl != 0, key_ready);
        check_flag("overflow", exp_overflow, overflow);
        check_flag("frame_error", exp_frame_error, frame_error);
        check_count("press_count", exp_count, dut0.ctrl0.press_count);
        exp_seg[0] = BLANK;
        exp_seg[1] = BLANK;
        if (lvl != 0) begin
            check_entry("head", exp_q[0], head);
            exp_seg[0] = glyph[exp_q[0].code[3:0]];
            exp_seg[1] = glyph[exp_q[0].code[7:4]];
        end
        exp_seg[2] = glyph[cnt % 10];
        exp_seg[3] = (cnt < 10) ? BLANK : glyph[(cnt / 10) % 10];
        exp_seg[4] = (cnt < 100) ? BLANK : glyph[cnt / 100];
        exp_seg[5] = glyph[lvl];
        for (int i = 0; i < 6; i++) begin
            check_seg($sformatf("seg[%0d]", i), exp_seg[i], seg[i]);
        end
    endtask

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    task automatic reset_dut;
        @(negedge clk);
        rst      = 1'b1;
        next_key = 1'b0;
        ps2_clk  = 1'b1;
        ps2_data = 1'b1;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        exp_q.delete();
        exp_count       = '0;
        exp_overflow    = 1'b0;
        exp_frame_error = 1'b0;
        brk_pend        = 1'b0;
        ext_pend        = 1'b0;
        held_valid      = 1'b0;
        @(negedge clk);
        check_state();
    endtask

    // One PS/2 frame, 20 clk cycles per bit, data changes while ps2_clk is high.
    task automatic send_frame(input logic [7:0] data, input bit bad_parity, input bit bad_stop);
        logic [10:0] bits;
        bits = {~bad_stop, ~(^data) ^ bad_parity, data, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(negedge clk);
            ps2_data = bits[i];
            repeat (5) @(negedge clk);
            ps2_clk = 1'b0;
            repeat (10) @(negedge clk);
            ps2_clk = 1'b1;
            repeat (4) @(negedge clk);
        end
        ps2_data = 1'b1;
        repeat (SETTLE) @(negedge clk);
        model_frame(data, bad_parity || bad_stop);
        check_state();
    endtask

    task automatic pop_key;
        @(negedge clk);
        next_key = 1'b1;
        @(negedge clk);
        next_key = 1'b0;
        if (exp_q.size() != 0) begin
            void'(exp_q.pop_front());
        end
        check_state();
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------
    task automatic make_order_test;
        reset_dut();
        send_frame(8'h1C, 0, 0);
        send_frame(`KBD_EXT_CODE, 0, 0);
        send_frame(8'h75, 0, 0);                              // Extended key.
        send_frame(8'h32, 0, 0);
        repeat (3) pop_key();
        pop_key();                                            // Pop on empty.
    endtask

    task automatic break_repeat_test;
        reset_dut();
        send_frame(8'h1C, 0, 0);
        send_frame(8'h1C, 0, 0);                              // Repeat, not counted.
        send_frame(`KBD_BREAK_CODE, 0, 0);
        send_frame(8'h1C, 0, 0);
        send_frame(8'h1C, 0, 0);                              // New press after release.
        send_frame(8'h2B, 0, 0);
        send_frame(`KBD_EXT_CODE, 0, 0);
        send_frame(8'h75, 0, 0);
        send_frame(`KBD_EXT_CODE, 0, 0);
        send_frame(8'h75, 0, 0);                              // Extended repeat, not counted.
        repeat (6) pop_key();
    endtask

    task automatic frame_error_test;
        reset_dut();
        send_frame(8'h1C, 1, 0);
        send_frame(8'h22, 0, 1);
        send_frame(8'h1C, 0, 0);
        pop_key();
    endtask

    task automatic overflow_test;
        reset_dut();
        for (int i = 0; i < 9; i++) begin
            send_frame(8'h15 + i[7:0], 0, 0);
        end
        repeat (8) pop_key();
    endtask

    task automatic random_key_test;
        logic [7:0] code;
        reset_dut();
        for (int i = 0; i < 16; i++) begin
            code = $random(seed);
            while (code == `KBD_EXT_CODE || code == `KBD_BREAK_CODE) begin
                code = $random(seed);
            end
            send_frame(code, 0, 0);
            if ($random(seed) & 1) begin
                pop_key();
            end
        end
        while (exp_q.size() != 0) begin
            pop_key();
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        ps2_clk   = 1'b1;
        ps2_data  = 1'b1;
        next_key  = 1'b0;
        n_checks  = 0;
        n_errors  = 0;
        cycle_cnt = 0;
        seed      = 32'h1fdd;
        load_glyphs();

        make_order_test();
        break_repeat_test();
        frame_error_test();
        overflow_test();
        random_key_test();

        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
